//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= receive_tb
FILELIST  ?= receive_chain.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/adc_frontend.sv
/* adc front end
   stamps each input beat with the cycle counter and builds differentiated sources */
`timescale 1ns/1ns
`include "rx_defines.svh"

module adc_frontend (
  input  logic                    clk,
  input  logic                    reset,
  input  rx_pkg::beat_t           adc_data [`RX_CHANNELS],
  input  logic [`RX_CHANNELS-1:0] adc_valid,
  sample_bus_if.source            out       // 2*RX_CHANNELS sources
);
  import rx_pkg::*;

  tstamp_t tstamp_count;                 // free running, 0 right after reset
  sample_t last_sample [`RX_CHANNELS];   // newest sample of previous valid beat
  beat_t   diff_beat   [`RX_CHANNELS];

  ////////////////////
  // differentiator
  ////////////////////
  always_comb begin
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      diff_beat[c][0] = adc_data[c][0] - last_sample[c]; // across beat boundary
      for (int i = 1; i < `RX_PARALLEL; i++) begin
        diff_beat[c][i] = adc_data[c][i] - adc_data[c][i-1]; // wraps at sample width
      end
    end
  end

  ////////////////////
  // control registers
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      tstamp_count <= '0;
      for (int c = 0; c < `RX_CHANNELS; c++) begin
        out.valid[c] <= 1'b0;
        out.valid[`RX_CHANNELS + c] <= 1'b0;
        last_sample[c] <= '0;
      end
    end else begin
      tstamp_count <= tstamp_count + 1'b1;
      for (int c = 0; c < `RX_CHANNELS; c++) begin
        out.valid[c] <= adc_valid[c];                 // raw source
        out.valid[`RX_CHANNELS + c] <= adc_valid[c];  // differentiated source
        if (adc_valid[c]) begin
          last_sample[c] <= adc_data[c][`RX_PARALLEL-1]; // only valid beats advance it
        end
      end
    end
  end

  // payload, stamped with the count of the input cycle
  always_ff @(posedge clk) begin
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      out.data[c] <= adc_data[c];
      out.data[`RX_CHANNELS + c] <= diff_beat[c];
      out.tstamp[c] <= tstamp_count;
      out.tstamp[`RX_CHANNELS + c] <= tstamp_count;
    end
  end

endmodule

//--- design/channel_mux.sv
/* channel mux
   registers one of the raw or differentiated sources onto each logical channel */
`timescale 1ns/1ns
`include "rx_defines.svh"

module channel_mux (
  input  logic             clk,
  input  logic             reset,
  input  rx_pkg::src_sel_t mux_select [`RX_CHANNELS], // source per logical channel
  sample_bus_if.sink       in,                        // 2*RX_CHANNELS sources
  sample_bus_if.source     out                        // RX_CHANNELS logical channels
);

  localparam int N_SRC = 2 * `RX_CHANNELS; // sources on the input bus

  logic src_ok [`RX_CHANNELS]; // select points at a real source

  // select codes past the last source give a silent channel
  always_comb begin
    for (int l = 0; l < `RX_CHANNELS; l++) begin
      src_ok[l] = (int'(mux_select[l]) < N_SRC);
    end
  end

  ////////////////////
  // valid path
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int l = 0; l < `RX_CHANNELS; l++) begin
        out.valid[l] <= 1'b0;
      end
    end else begin
      for (int l = 0; l < `RX_CHANNELS; l++) begin
        out.valid[l] <= src_ok[l] && in.valid[mux_select[l]];
      end
    end
  end

  ////////////////////
  // payload path
  ////////////////////
  // two logical channels may read the same source
  always_ff @(posedge clk) begin
    for (int l = 0; l < `RX_CHANNELS; l++) begin
      out.data[l] <= in.data[mux_select[l]];     // beat follows the select
      out.tstamp[l] <= in.tstamp[mux_select[l]]; // so does its timestamp
    end
  end

endmodule

//--- design/receive_top.sv
/* receive chain top
   front end, channel mux, discriminator and sample buffer behind plain ports */
`timescale 1ns/1ns
`include "rx_defines.svh"

module receive_top (
  input  logic                    clk,
  input  logic                    reset,
  // adc input, one beat per channel per cycle, no ready
  input  rx_pkg::beat_t           adc_data    [`RX_CHANNELS],
  input  logic [`RX_CHANNELS-1:0] adc_valid,
  // static configuration levels
  input  rx_pkg::src_sel_t        mux_select  [`RX_CHANNELS],
  input  rx_pkg::sample_t         threshold   [`RX_CHANNELS],
  input  logic                    capture_arm,
  // readout stream
  output logic                    out_valid,
  input  logic                    out_ready,
  output rx_pkg::beat_t           out_data,
  output rx_pkg::tstamp_t         out_tstamp,
  output rx_pkg::chan_t           out_channel,
  output logic                    out_overflow
);

  ////////////////////
  // stage buses
  ////////////////////
  sample_bus_if #(.n_chan(2 * `RX_CHANNELS)) front_bus (); // raw then differentiated
  sample_bus_if #(.n_chan(`RX_CHANNELS)) logic_bus ();     // logical channels
  sample_bus_if #(.n_chan(`RX_CHANNELS)) kept_bus ();      // beats over threshold

  ////////////////////
  // stages
  ////////////////////
  adc_frontend frontend_i (
    .clk,
    .reset,
    .adc_data,
    .adc_valid,
    .out(front_bus)
  );

  channel_mux channel_mux_i (
    .clk,
    .reset,
    .mux_select,
    .in (front_bus),
    .out(logic_bus)
  );

  sample_discriminator discriminator_i (
    .clk,
    .reset,
    .threshold,
    .in (logic_bus),
    .out(kept_bus)
  );

  // three cycles after input a kept beat lands in its FIFO
  sample_buffer buffer_i (
    .clk,
    .reset,
    .capture_arm,
    .in(kept_bus),
    .out_valid,
    .out_ready,
    .out_data,
    .out_tstamp,
    .out_channel,
    .out_overflow
  );

endmodule

//--- design/rx_defines.svh
/* receive chain sizing
   channel count, beat shape, timestamp width and buffer depth */
`ifndef RX_DEFINES_SVH
`define RX_DEFINES_SVH

////////////////////
// channels and beats
////////////////////
`define RX_CHANNELS 2         // physical channels, also logical channels after the mux
`define RX_PARALLEL 2         // samples per beat per channel
`define RX_SAMPLE_WIDTH 16    // signed sample width in bits

////////////////////
// timestamps and buffering
////////////////////
`define RX_TSTAMP_WIDTH 32    // free-running cycle counter width
`define RX_FIFO_DEPTH 8       // entries in each per-channel FIFO

`endif

//--- design/rx_pkg.sv
/* receive chain shared types
   samples, beats, timestamps and the mux/channel index types */
`include "rx_defines.svh"

package rx_pkg;

  // index widths, source index covers raw plus differentiated channels
  localparam int SRC_BITS = $clog2(2 * `RX_CHANNELS);
  localparam int CHAN_BITS = (`RX_CHANNELS > 1) ? $clog2(`RX_CHANNELS) : 1;

  ////////////////////
  // data types
  ////////////////////
  typedef logic signed [`RX_SAMPLE_WIDTH-1:0] sample_t; // one adc sample

  // sample 0 is the oldest, sits in the low bits
  typedef sample_t [`RX_PARALLEL-1:0] beat_t;

  typedef logic [`RX_TSTAMP_WIDTH-1:0] tstamp_t; // cycle count

  ////////////////////
  // index types
  ////////////////////
  // 0..CH-1 raw channels, CH..2CH-1 differentiated in the same order
  typedef logic [SRC_BITS-1:0] src_sel_t;
  typedef logic [CHAN_BITS-1:0] chan_t;   // logical channel number

endpackage

//--- design/sample_buffer.sv
/* sample buffer
   per-channel beat and timestamp FIFOs filled while armed, round-robin readout
   on a valid/ready stream with a sticky overflow flag */
`timescale 1ns/1ns
`include "rx_defines.svh"

module sample_buffer (
  input  logic            clk,
  input  logic            reset,
  input  logic            capture_arm,  // level, gates writes only
  sample_bus_if.sink      in,
  output logic            out_valid,
  input  logic            out_ready,
  output rx_pkg::beat_t   out_data,
  output rx_pkg::tstamp_t out_tstamp,
  output rx_pkg::chan_t   out_channel,  // channel being presented, last served otherwise
  output logic            out_overflow  // sticky until reset
);
  import rx_pkg::*;

  logic    push       [`RX_CHANNELS];
  logic    pop        [`RX_CHANNELS];
  logic    beat_full  [`RX_CHANNELS];
  logic    ts_full    [`RX_CHANNELS];
  logic    beat_empty [`RX_CHANNELS];
  logic    ts_empty   [`RX_CHANNELS];
  logic    has_data   [`RX_CHANNELS];
  beat_t   beat_head  [`RX_CHANNELS];
  tstamp_t ts_head    [`RX_CHANNELS];
  logic    push_blocked; // kept beat hit a full FIFO this cycle
  logic    next_found;
  chan_t   next_chan;
  logic    transfer;

  assign transfer = out_valid && out_ready;

  // heads only move on a pop, so these hold under back-pressure
  assign out_data = beat_head[out_channel];
  assign out_tstamp = ts_head[out_channel];

  ////////////////////
  // channel FIFOs
  ////////////////////
  for (genvar c = 0; c < `RX_CHANNELS; c++) begin : g_chan
    assign push[c] = capture_arm && in.valid[c];
    assign pop[c] = transfer && (out_channel == chan_t'(c));
    assign has_data[c] = !beat_empty[c] && !ts_empty[c];

    stream_fifo #(
      .payload_t(beat_t),
      .depth    (`RX_FIFO_DEPTH)
    ) beat_fifo (
      .clk,
      .reset,
      .push     (push[c]),
      .push_data(in.data[c]),
      .full     (beat_full[c]),
      .pop      (pop[c]),
      .pop_data (beat_head[c]),
      .empty    (beat_empty[c])
    );

    stream_fifo #(
      .payload_t(tstamp_t),
      .depth    (`RX_FIFO_DEPTH)
    ) ts_fifo (
      .clk,
      .reset,
      .push     (push[c]),      // written together with the beat
      .push_data(in.tstamp[c]),
      .full     (ts_full[c]),
      .pop      (pop[c]),
      .pop_data (ts_head[c]),
      .empty    (ts_empty[c])
    );
  end

  // any channel dropping a kept beat
  always_comb begin
    push_blocked = 1'b0;
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      if (push[c] && (beat_full[c] || ts_full[c])) push_blocked = 1'b1;
    end
  end

  ////////////////////
  // round-robin pick
  ////////////////////
  // first non-empty channel after the one last served
  always_comb begin
    int idx;
    next_found = 1'b0;
    next_chan = out_channel;
    for (int k = 1; k <= `RX_CHANNELS; k++) begin
      idx = (int'(out_channel) + k) % `RX_CHANNELS;
      if (!next_found && has_data[idx]) begin
        next_found = 1'b1;
        next_chan = chan_t'(idx);
      end
    end
  end

  ////////////////////
  // readout state
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      out_channel <= chan_t'(`RX_CHANNELS - 1); // channel 0 gets served first
      out_overflow <= 1'b0;
    end else begin
      if (push_blocked) out_overflow <= 1'b1;
      if (transfer) begin
        out_valid <= 1'b0;  // one idle cycle while the FIFO count settles
      end else if (!out_valid && next_found) begin
        out_valid <= 1'b1;
        out_channel <= next_chan;
      end
    end
  end

endmodule

//--- design/sample_bus_if.sv
/* per-channel beat bus between receive stages
   data, valid and timestamp per channel, no back-pressure */
`timescale 1ns/1ns

interface sample_bus_if #(
  parameter int n_chan = 2  // channels carried on this bus
);
  import rx_pkg::*;

  beat_t   data   [n_chan]; // one beat per channel
  logic    valid  [n_chan]; // qualifies that channel's beat only
  tstamp_t tstamp [n_chan]; // input cycle of the beat

  // upstream stage
  modport source (
    output data,
    output valid,
    output tstamp
  );

  // downstream stage, never stalls
  modport sink (
    input data,
    input valid,
    input tstamp
  );

endinterface

//--- design/sample_discriminator.sv
/* sample discriminator
   passes a beat only when one of its samples reaches the channel threshold */
`timescale 1ns/1ns
`include "rx_defines.svh"

module sample_discriminator (
  input  logic            clk,
  input  logic            reset,
  input  rx_pkg::sample_t threshold [`RX_CHANNELS], // signed level per logical channel
  sample_bus_if.sink      in,
  sample_bus_if.source    out
);

  logic hit [`RX_CHANNELS]; // some sample at or above threshold

  ////////////////////
  // threshold compare
  ////////////////////
  always_comb begin
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      hit[c] = 1'b0;
      for (int i = 0; i < `RX_PARALLEL; i++) begin
        // signed compare, negative thresholds are legal
        if ($signed(in.data[c][i]) >= $signed(threshold[c])) begin
          hit[c] = 1'b1;
        end
      end
    end
  end

  ////////////////////
  // output registers
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int c = 0; c < `RX_CHANNELS; c++) begin
        out.valid[c] <= 1'b0;
      end
    end else begin
      for (int c = 0; c < `RX_CHANNELS; c++) begin
        out.valid[c] <= in.valid[c] && hit[c]; // quiet beats vanish here
      end
    end
  end

  // payload goes through untouched, valid decides if it counts
  always_ff @(posedge clk) begin
    for (int c = 0; c < `RX_CHANNELS; c++) begin
      out.data[c] <= in.data[c];
      out.tstamp[c] <= in.tstamp[c];
    end
  end

endmodule

//--- design/stream_fifo.sv
/* synchronous first-word-fall-through FIFO
   payload type set by parameter, push when full and pop when empty are ignored */
`timescale 1ns/1ns

module stream_fifo #(
  parameter type payload_t = logic [7:0], // entry type
  parameter int  depth     = 8            // number of entries
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     push,
  input  payload_t push_data,
  output logic     full,
  input  logic     pop,
  output payload_t pop_data,  // head entry, valid while not empty
  output logic     empty
);

  localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
  localparam int CNT_W = $clog2(depth + 1);

  payload_t         mem [depth];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;   // entries held
  logic             do_push;
  logic             do_pop;

  // wrap works for any depth, not only powers of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full = (count == CNT_W'(depth));
  assign empty = (count == '0);
  assign do_push = push && !full;
  assign do_pop = pop && !empty;
  assign pop_data = mem[rd_ptr]; // fall through

  ////////////////////
  // pointers and count
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_next(wr_ptr);
      if (do_pop) rd_ptr <= ptr_next(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= push_data;
  end

endmodule

//--- receive_chain.f
+incdir+design
+incdir+tb
design/rx_pkg.sv
design/sample_bus_if.sv
design/adc_frontend.sv
design/channel_mux.sv
design/sample_discriminator.sv
design/stream_fifo.sv
design/sample_buffer.sv
design/receive_top.sv
tb/receive_tb.sv

//--- tb/receive_tests.svh
/* directed tests for the receive chain
   each sets up the chain and drives beats while the collector checks the readout */

  // identity select with every sample kept, capture armed and ready high
  task automatic default_config();
    for (int l = 0; l < CH; l++) begin
      mux_select[l] = src_sel_t'(l);
      threshold[l] = MIN_SAMPLE;
    end
    capture_arm = 1'b1;
    ready_mode = 0;
  endtask

  task automatic random_burst(input int n, input logic random_valid);
    repeat (n) begin
      for (int c = 0; c < CH; c++) begin
        stim[c] = rand_beat();
      end
      stim_valid = random_valid ? CH'($random(seed)) : '1;
      drive_cycle();
    end
  endtask

  task automatic raw_passthrough();
    apply_reset();
    default_config();
    repeat (3) begin
      random_burst(6, 1'b0); // short bursts keep the FIFOs from filling
      wait_drained();
    end
    check_value(!out_overflow, "overflow set on a drained stream");
    finish_test("raw pass-through");
  endtask

  task automatic differentiator_steps();
    apply_reset();
    default_config();
    for (int l = 0; l < CH; l++) begin
      mux_select[l] = src_sel_t'(CH + l);  // differentiated copy of the same channel
    end
    // ramps with a small step on channel 0 and wrapping samples elsewhere
    for (int k = 0; k < 6; k++) begin
      for (int c = 0; c < CH; c++) begin
        for (int i = 0; i < P; i++) begin
          stim[c][i] = sample_t'((k * P + i) * ((c == 0) ? 7 : 12289));
        end
      end
      stim_valid = '1;
      drive_cycle();
      if (k % 2 == 1) begin
        idle_cycles(2);  // the differentiator history holds across the gap
      end
    end
    wait_drained();
    random_burst(8, 1'b1);
    wait_drained();
    finish_test("differentiator");
  endtask

  task automatic crossed_mux();
    apply_reset();
    default_config();
    mux_select[0] = src_sel_t'(1);   // raw channel 1
    mux_select[1] = src_sel_t'(CH);  // differentiated channel 0
    repeat (2) begin
      random_burst(6, 1'b1);
      wait_drained();
    end
    finish_test("crossed mux");
  endtask

  task automatic threshold_filter();
    apply_reset();
    default_config();
    threshold[0] = sample_t'(100);
    threshold[1] = sample_t'(-50);
    repeat (2) begin
      repeat (8) begin
        for (int c = 0; c < CH; c++) begin
          for (int i = 0; i < P; i++) begin
            // within 3 of the level either way
            stim[c][i] = sample_t'(int'(threshold[c]) + $random(seed) % 4);
          end
        end
        stim_valid = '1;
        drive_cycle();
      end
      wait_drained();
    end
    finish_test("discriminator");
  endtask

  task automatic arming_and_backpressure();
    apply_reset();
    default_config();
    capture_arm = 1'b0;
    ready_mode = 1;  // out_ready held low so a captured beat stays presented
    random_burst(6, 1'b0);
    idle_cycles(10);
    check_value(!out_valid, "readout produced data while disarmed");
    capture_arm = 1'b1;
    for (int n = 0; n < `RX_FIFO_DEPTH + 4; n++) begin
      stim[0] = rand_beat();
      stim_valid = CH'(1);  // channel 0 only
      drive_cycle();
    end
    idle_cycles(4);
    check_value(out_overflow, "overflow not flagged after overfilling channel 0");
    ready_mode = 2;  // first entries drain under random ready
    wait_drained();
    repeat (3) begin
      random_burst(4, 1'b0);
      wait_drained();
    end
    check_value(out_overflow, "overflow cleared without reset");
    finish_test("arming and back-pressure");
  endtask

  task automatic round_robin_order();
    apply_reset();
    default_config();
    ready_mode = 1;
    random_burst(4, 1'b0);  // four entries on every channel
    idle_cycles(4);
    served_q.delete();
    ready_mode = 0;
    wait_drained();
    check_value(served_q.size() == CH * 4, "round-robin readout count wrong");
    for (int i = 1; i < served_q.size(); i++) begin
      check_value(served_q[i] != served_q[i-1],
                  $sformatf("channel %0d served twice in a row", served_q[i]));
    end
    finish_test("round-robin");
  endtask

//--- tb/receive_tb.sv
/* receive chain testbench
   drives ADC beats into the DUT, models the kept beats per logical channel
   and checks every readout transfer against that model */
`timescale 1ns/1ns
`include "rx_defines.svh"

module receive_tb;
  import rx_pkg::*;

  localparam int CH = `RX_CHANNELS;
  localparam int P = `RX_PARALLEL;
  localparam int WAIT_LIMIT = 500;  // cycles before a wait gives up
  localparam sample_t MIN_SAMPLE = {1'b1, {(`RX_SAMPLE_WIDTH-1){1'b0}}}; // most negative

  // DUT side
  logic          clk;
  logic          reset;
  beat_t         adc_data   [CH];
  logic [CH-1:0] adc_valid;
  src_sel_t      mux_select [CH];
  sample_t       threshold  [CH];
  logic          capture_arm;
  logic          out_valid;
  logic          out_ready;
  beat_t         out_data;
  tstamp_t       out_tstamp;
  chan_t         out_channel;
  logic          out_overflow;

  // stimulus and bookkeeping
  integer        seed;
  int            error_count;
  int            check_count;
  int            test_start_errors;
  int            ready_mode;         // 0 ready high, 1 held low, 2 random
  tstamp_t       cycle_count;        // input cycle counted from 0 after reset
  beat_t         stim       [CH];    // next beat per channel
  logic [CH-1:0] stim_valid;

  // reference model
  sample_t       last_sample [CH];   // newest sample of the last valid beat
  beat_t         exp_beat_q  [CH][$];
  tstamp_t       exp_ts_q    [CH][$];
  chan_t         served_q    [$];    // channel of each transfer in order

  // readout as seen while stalled
  logic          stall_seen;
  beat_t         held_data;
  tstamp_t       held_tstamp;
  chan_t         held_channel;

  receive_top DUT (
    .clk,
    .reset,
    .adc_data,
    .adc_valid,
    .mux_select,
    .threshold,
    .capture_arm,
    .out_valid,
    .out_ready,
    .out_data,
    .out_tstamp,
    .out_channel,
    .out_overflow
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  ////////////////////
  // checks
  ////////////////////
  task automatic check_value(input logic ok, input string what);
    check_count++;
    assert (ok) else begin
      $display("Fail at %0t: %s", $time, what);
      error_count++;
    end
  endtask

  function automatic int pending_beats();
    int n;
    n = 0;
    for (int c = 0; c < CH; c++) begin
      n += exp_beat_q[c].size();
    end
    return n;
  endfunction

  ////////////////////
  // readout collector
  ////////////////////
  // transfer at the coming rising edge, read while the fields are stable mid-cycle
  task automatic take_transfer();
    int ch;
    ch = int'(out_channel);
    served_q.push_back(out_channel);
    if (exp_beat_q[ch].size() == 0) begin
      check_value(1'b0, $sformatf("beat read on channel %0d with none expected", ch));
    end else begin
      check_value(out_data == exp_beat_q[ch][0],
                  $sformatf("ch%0d data %h, expected %h", ch, out_data, exp_beat_q[ch][0]));
      check_value(out_tstamp == exp_ts_q[ch][0],
                  $sformatf("ch%0d tstamp %0d, expected %0d", ch, out_tstamp, exp_ts_q[ch][0]));
      void'(exp_beat_q[ch].pop_front());
      void'(exp_ts_q[ch].pop_front());
    end
  endtask

  // picks out_ready for the next edge and checks the handshake
  task automatic service_readout();
    logic ready_now;
    ready_now = 1'b0;
    if (reset) begin
      stall_seen = 1'b0;
    end else begin
      ready_now = (ready_mode == 0) || (ready_mode == 2 && ($random(seed) & 1) == 1);
      if (stall_seen) begin // fields hold after a stalled edge
        check_value(out_valid && out_data == held_data && out_tstamp == held_tstamp &&
                    out_channel == held_channel, "readout fields moved while stalled");
      end
      if (out_valid && ready_now) take_transfer();
      stall_seen = out_valid && !ready_now;
    end
    held_data = out_data;
    held_tstamp = out_tstamp;
    held_channel = out_channel;
    out_ready = ready_now;
  endtask

  ////////////////////
  // stimulus and model
  ////////////////////
  task automatic tick();
    @(negedge clk);
    if (!reset) cycle_count = cycle_count + 1'b1;
    service_readout();
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    adc_valid = '0;
    stim_valid = '0;
    for (int c = 0; c < CH; c++) begin
      last_sample[c] = '0;    // differentiator history starts at 0
      exp_beat_q[c].delete();
      exp_ts_q[c].delete();
    end
    served_q.delete();
    repeat (16) tick();
    reset = 1'b0;
    cycle_count = '0;
  endtask

  // one input cycle in which the model records what each logical channel keeps
  task automatic drive_cycle();
    beat_t diff [CH];
    beat_t src_beat;
    int    src;
    logic  hit;
    tick();
    for (int c = 0; c < CH; c++) begin
      diff[c][0] = stim[c][0] - last_sample[c]; // across the beat boundary
      for (int i = 1; i < P; i++) begin
        diff[c][i] = stim[c][i] - stim[c][i-1];
      end
    end
    for (int l = 0; l < CH; l++) begin
      src = int'(mux_select[l]);
      src_beat = (src < CH) ? stim[src] : diff[src - CH]; // raw sources before differentiated
      hit = 1'b0;
      for (int i = 0; i < P; i++) begin
        if ($signed(src_beat[i]) >= $signed(threshold[l])) hit = 1'b1;
      end
      // a beat meeting a full FIFO is lost
      if (capture_arm && stim_valid[src % CH] && hit &&
          exp_beat_q[l].size() < `RX_FIFO_DEPTH) begin
        exp_beat_q[l].push_back(src_beat);
        exp_ts_q[l].push_back(cycle_count);
      end
    end
    for (int c = 0; c < CH; c++) begin
      if (stim_valid[c]) last_sample[c] = stim[c][P-1];
    end
    adc_data = stim;
    adc_valid = stim_valid;
  endtask

  task automatic idle_cycles(input int n);
    stim_valid = '0;
    repeat (n) drive_cycle();
  endtask

  // runs idle input until the model has seen every expected beat
  task automatic wait_drained();
    int waited;
    waited = 0;
    stim_valid = '0;
    while (pending_beats() > 0 && waited < WAIT_LIMIT) begin
      drive_cycle();
      waited++;
    end
    if (pending_beats() > 0) begin
      $display("wait for readout timed out with %0d beats still expected", pending_beats());
      error_count++;
    end
    idle_cycles(6);  // room for a stray beat
    check_value(!out_valid, "readout still valid after all expected beats");
  endtask

  function automatic beat_t rand_beat();
    beat_t b;
    for (int i = 0; i < P; i++) begin
      b[i] = sample_t'($random(seed));
    end
    return b;
  endfunction

  task automatic finish_test(input string name);
    $display("test %s: %0d errors", name, error_count - test_start_errors);
    test_start_errors = error_count;
  endtask

  `include "receive_tests.svh"

  ////////////////////
  // main sequence
  ////////////////////
  initial begin
    seed = 82;
    error_count = 0;
    check_count = 0;
    test_start_errors = 0;
    ready_mode = 0;
    reset = 1'b1;
    out_ready = 1'b0;
    capture_arm = 1'b0;
    adc_valid = '0;
    stim_valid = '0;
    cycle_count = '0;
    for (int c = 0; c < CH; c++) begin
      adc_data[c] = '0;
      stim[c] = '0;
      mux_select[c] = src_sel_t'(c);
      threshold[c] = MIN_SAMPLE;
    end
    raw_passthrough();
    differentiator_steps();
    crossed_mux();
    threshold_filter();
    arming_and_backpressure();
    round_robin_order();
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule
